/* rtl/soc_bus_pkg.sv */
`default_nettype none

package soc_bus_pkg;

    localparam int addr_w = 32;
    localparam int data_w = 32;
    localparam int mask_w = 4;      // one enable bit per byte lane

    // instruction fetches only ever read
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              read;
    } instr_req_t;

    // full request, used by the data master and on the common bus
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic              read;
        logic              write;
        logic [mask_w-1:0] wmask;
        logic [data_w-1:0] wdata;
    } bus_req_t;

    // ready is a single-cycle pulse that ends the transfer
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              ready;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* rtl/soc_map_pkg.sv */
`default_nettype none

package soc_map_pkg;

    localparam int region_w  = 16;
    localparam int ram_words = 16384;
    localparam int ram_idx_w = $clog2(ram_words);

    // regions are matched against addr[31:16]
    localparam logic [region_w-1:0] region_ram   = 16'h0000;
    localparam logic [region_w-1:0] region_gpio  = 16'h0001;
    localparam logic [region_w-1:0] region_timer = 16'h0003;

    localparam logic [1:0] gpio_reg_data = 2'd0;
    localparam logic [1:0] gpio_reg_set  = 2'd1;
    localparam logic [1:0] gpio_reg_clr  = 2'd2;

    localparam logic [1:0] timer_reg_lo = 2'd0;
    localparam logic [1:0] timer_reg_hi = 2'd1;

    // one address word, seen either as a RAM index or as a peripheral register
    typedef union packed {
        struct packed {
            logic [region_w-1:0]  region;
            logic [ram_idx_w-1:0] word;
            logic [1:0]           byte_off;
        } ram;
        struct packed {
            logic [region_w-1:0] region;
            logic [11:0]         pad;
            logic [1:0]          reg_idx;
            logic [1:0]          byte_off;
        } mmio;
    } mem_addr_u;

    typedef struct packed {
        logic ram;
        logic gpio;
        logic timer;
        logic unmapped;
    } target_sel_t;

endpackage

`default_nettype wire

/* rtl/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
    import soc_bus_pkg::*;
(
    input  wire logic       pll_clk,
    input  wire logic       arst_n,
    input  wire instr_req_t instr_req,
    output bus_rsp_t        instr_rsp,
    input  wire bus_req_t   data_req,
    output bus_rsp_t        data_rsp,
    output bus_req_t        mem_req,
    input  wire bus_rsp_t   mem_rsp
);

    logic     locked;
    logic     owner_data;     // which master holds the lock
    logic     data_active;
    logic     grant_data;
    logic     grant_instr;
    bus_req_t instr_wide;

    assign data_active = data_req.read | data_req.write;

    // data wins a tie, but only while the bus is free
    assign grant_data  = locked ? owner_data  : data_active;
    assign grant_instr = locked ? ~owner_data : (~data_active & instr_req.read);

    assign instr_wide = '{
        addr:  instr_req.addr,
        read:  instr_req.read,
        write: 1'b0,
        wmask: '0,
        wdata: '0
    };

    always_comb begin
        if (grant_data) begin
            mem_req = data_req;
        end else if (grant_instr) begin
            mem_req = instr_wide;
        end else begin
            mem_req = '0;
        end
    end

    // ==================================================================
    // the lock keeps the owner until the target answers
    // ==================================================================
    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            locked     <= 1'b0;
            owner_data <= 1'b0;
        end else if (mem_rsp.ready) begin
            locked <= 1'b0;
        end else if (!locked && (grant_data || grant_instr)) begin
            locked     <= 1'b1;
            owner_data <= grant_data;
        end
    end

    assign instr_rsp.rdata = grant_instr ? mem_rsp.rdata : '0;
    assign instr_rsp.ready = grant_instr & mem_rsp.ready;
    assign data_rsp.rdata  = grant_data ? mem_rsp.rdata : '0;
    assign data_rsp.ready  = grant_data & mem_rsp.ready;

    a_data_rw_excl: assert property (@(posedge pll_clk) disable iff (!arst_n)
        !(data_req.read && data_req.write));

    // an unfinished transfer keeps its address on the common bus
    a_req_held: assert property (@(posedge pll_clk) disable iff (!arst_n)
        (mem_req.read || mem_req.write) && !mem_rsp.ready |=> $stable(mem_req.addr));

endmodule

`default_nettype wire

/* rtl/addr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module addr_decoder
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire bus_req_t mem_req,
    output target_sel_t   sel
);

    mem_addr_u a;
    logic      active;
    logic      pad_zero;

    assign a        = mem_req.addr;
    assign active   = mem_req.read | mem_req.write;
    assign pad_zero = (a.mmio.pad == '0);   // peripherals only decode the low nibble

    always_comb begin
        sel = '0;
        if (active) begin
            case (a.ram.region)
                region_ram:   sel.ram = 1'b1;
                region_gpio:  begin
                    sel.gpio     = pad_zero;
                    sel.unmapped = ~pad_zero;
                end
                region_timer: begin
                    sel.timer    = pad_zero;
                    sel.unmapped = ~pad_zero;
                end
                default:      sel.unmapped = 1'b1;
            endcase
        end
        a_sel_onehot: assert final ($onehot0(sel));
    end

endmodule

`default_nettype wire

/* rtl/bus_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_ram
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic     pll_clk,
    input  wire logic     arst_n,
    input  wire bus_req_t mem_req,
    input  wire logic     sel,
    output bus_rsp_t      rsp
);

    logic [data_w-1:0] mem [ram_words] = '{default: '0};
    logic [data_w-1:0] rd_q;
    logic              pending;
    logic              start;
    mem_addr_u         a;

    assign a     = mem_req.addr;
    assign start = sel & ~pending;  // first cycle of a select

    always_ff @(posedge pll_clk) begin
        if (start && mem_req.write) begin
            for (int b = 0; b < mask_w; b++) begin
                if (mem_req.wmask[b]) begin
                    mem[a.ram.word][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
                end
            end
        end
        if (start) begin
            rd_q <= mem[a.ram.word];    // old contents on a write, nobody looks
        end
    end

    // the request is still held while pending is up, so it must not restart
    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            pending <= 1'b0;
        end else begin
            pending <= start;
        end
    end

    assign rsp.rdata = pending ? rd_q : '0;
    assign rsp.ready = pending;

endmodule

`default_nettype wire

/* rtl/gpio_leds.sv */
`timescale 1ns/1ps
`default_nettype none

module gpio_leds
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic     pll_clk,
    input  wire logic     arst_n,
    input  wire bus_req_t mem_req,
    input  wire logic     sel,
    output bus_rsp_t      rsp,
    output logic [7:0]    leds
);

    mem_addr_u  a;
    logic       wr;
    logic [7:0] wbits;

    assign a     = mem_req.addr;
    assign wr    = sel & mem_req.write & mem_req.wmask[0];   // only byte 0 is wired
    assign wbits = mem_req.wdata[7:0];

    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            leds <= '0;
        end else if (wr) begin
            case (a.mmio.reg_idx)
                gpio_reg_data: leds <= wbits;
                gpio_reg_set:  leds <= leds | wbits;
                gpio_reg_clr:  leds <= leds & ~wbits;
                default:       leds <= leds;
            endcase
        end
    end

    // every offset reads back the current pattern
    assign rsp.rdata = sel ? {{(data_w-8){1'b0}}, leds} : '0;
    assign rsp.ready = sel;

endmodule

`default_nettype wire

/* rtl/cycle_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module cycle_timer
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic     pll_clk,
    input  wire logic     arst_n,
    input  wire bus_req_t mem_req,
    input  wire logic     sel,
    output bus_rsp_t      rsp
);

    logic [2*data_w-1:0] count;
    logic [data_w-1:0]   rd_word;
    mem_addr_u           a;

    assign a = mem_req.addr;

    // ==================================================================
    // free-running counter
    // ==================================================================
    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_comb begin
        case (a.mmio.reg_idx)
            timer_reg_lo: rd_word = count[data_w-1:0];
            timer_reg_hi: rd_word = count[2*data_w-1:data_w];
            default:      rd_word = '0;
        endcase
    end

    // the two halves come from different cycles, software has to re-read hi
    // to catch a carry
    assign rsp.rdata = (sel && mem_req.read) ? rd_word : '0;
    assign rsp.ready = sel;     // writes are acked and dropped

endmodule

`default_nettype wire

/* rtl/response_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module response_mux
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire bus_rsp_t    ram_rsp,
    input  wire bus_rsp_t    gpio_rsp,
    input  wire bus_rsp_t    timer_rsp,
    input  wire target_sel_t sel,
    output bus_rsp_t         mem_rsp
);

    // idle targets drive zero, so OR is enough
    assign mem_rsp.rdata = ram_rsp.rdata | gpio_rsp.rdata | timer_rsp.rdata;
    assign mem_rsp.ready = ram_rsp.ready | gpio_rsp.ready | timer_rsp.ready
                         | sel.unmapped;     // unmapped answers at once with zero

    always_comb begin
        a_one_ready: assert final ($onehot0({ram_rsp.ready, gpio_rsp.ready,
                                             timer_rsp.ready, sel.unmapped}));
    end

endmodule

`default_nettype wire

/* rtl/soc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_top
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
(
    input  wire logic       pll_clk,
    input  wire logic       arst_n,
    input  wire instr_req_t instr_req,
    output bus_rsp_t        instr_rsp,
    input  wire bus_req_t   data_req,
    output bus_rsp_t        data_rsp,
    output logic [7:0]      leds
);

    bus_req_t    mem_req;
    bus_rsp_t    mem_rsp;
    target_sel_t sel;
    bus_rsp_t    ram_rsp;
    bus_rsp_t    gpio_rsp;
    bus_rsp_t    timer_rsp;

    bus_arbiter i_bus_arbiter (
        .pll_clk   (pll_clk),
        .arst_n    (arst_n),
        .instr_req (instr_req),
        .instr_rsp (instr_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    addr_decoder i_addr_decoder (
        .mem_req (mem_req),
        .sel     (sel)
    );

    // ==================================================================
    // targets
    // ==================================================================
    bus_ram i_bus_ram (
        .pll_clk (pll_clk),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .sel     (sel.ram),
        .rsp     (ram_rsp)
    );

    gpio_leds i_gpio_leds (
        .pll_clk (pll_clk),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .sel     (sel.gpio),
        .rsp     (gpio_rsp),
        .leds    (leds)
    );

    cycle_timer i_cycle_timer (
        .pll_clk (pll_clk),
        .arst_n  (arst_n),
        .mem_req (mem_req),
        .sel     (sel.timer),
        .rsp     (timer_rsp)
    );

    response_mux i_response_mux (
        .ram_rsp   (ram_rsp),
        .gpio_rsp  (gpio_rsp),
        .timer_rsp (timer_rsp),
        .sel       (sel),
        .mem_rsp   (mem_rsp)
    );

endmodule

`default_nettype wire

/* dv/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic pll_clk,
    output logic arst_n
);

    initial begin
        pll_clk = 1'b0;
        forever #2 pll_clk = ~pll_clk;  // 4 ns period
    end

    // release on a falling edge so the first rising edge sees a clean reset
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge pll_clk);
        @(negedge pll_clk);
        arst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* dv/soc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module soc_tb
    import soc_bus_pkg::*;
    import soc_map_pkg::*;
();

    localparam logic [31:0] seed = 32'hd5c8_eb24;
    localparam int n_ram     = 32;
    localparam int n_gpio    = 12;
    localparam int n_timer   = 8;
    localparam int n_odd     = 5;
    localparam int n_contend = 20;
    // seven single accesses plus the loops
    localparam int n_ops = 7 + 2*n_ram + 2*n_gpio + n_timer + 2*n_odd + 2*n_contend;

    logic       pll_clk;
    logic       arst_n;
    instr_req_t instr_req;
    bus_rsp_t   instr_rsp;
    bus_req_t   data_req;
    bus_rsp_t   data_rsp;
    logic [7:0] leds;

    logic [data_w-1:0] shadow_ram [ram_words] = '{default: '0};
    logic [7:0]        shadow_leds = '0;
    logic [63:0]       cyc;
    logic [addr_w-1:0] odd_addr [n_odd] = '{32'h0002_0000, 32'h0004_0010, 32'hffff_fffc,
                                            32'h0001_0104, 32'h0003_0040};
    logic [addr_w-1:0] addr_q [$];
    logic [63:0]       cyc_q [$];
    logic [data_w-1:0] got_q [$];
    logic [data_w-1:0] exp_q [$];
    string             name_q [$];
    int                issued = 0;
    int                checked = 0;

    tb_clock i_tb_clock (
        .pll_clk (pll_clk),
        .arst_n  (arst_n)
    );

    soc_top i_soc_top (
        .pll_clk   (pll_clk),
        .arst_n    (arst_n),
        .instr_req (instr_req),
        .instr_rsp (instr_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .leds      (leds)
    );

    always @(posedge pll_clk) begin
        if (!arst_n) begin
            cyc <= '0;
        end else begin
            cyc <= cyc + 64'd1;     // reads 0 in the first edge after release
        end
    end

    task automatic stop_on_failure();
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    // ======================================================================
    // reference model
    // ======================================================================
    function automatic logic [data_w-1:0] ref_read(input logic [addr_w-1:0] addr,
                                                   input logic [63:0] cycle);
        mem_addr_u a;
        a = addr;
        if (a.ram.region == region_ram) begin
            return shadow_ram[a.ram.word];
        end
        if (a.mmio.pad != '0) begin
            return '0;
        end
        if (a.mmio.region == region_gpio) begin
            return {24'h0, shadow_leds};
        end
        if (a.mmio.region == region_timer && a.mmio.reg_idx == timer_reg_lo) begin
            return cycle[31:0];
        end
        if (a.mmio.region == region_timer && a.mmio.reg_idx == timer_reg_hi) begin
            return cycle[63:32];
        end
        return '0;
    endfunction

    function automatic void model_write(input logic [addr_w-1:0] addr,
                                        input logic [mask_w-1:0] mask,
                                        input logic [data_w-1:0] wdata);
        mem_addr_u a;
        a = addr;
        if (a.ram.region == region_ram) begin
            for (int b = 0; b < mask_w; b++) begin
                if (mask[b]) begin
                    shadow_ram[a.ram.word][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end else if (a.mmio.region == region_gpio && a.mmio.pad == '0 && mask[0]) begin
            case (a.mmio.reg_idx)
                gpio_reg_data: shadow_leds = wdata[7:0];
                gpio_reg_set:  shadow_leds = shadow_leds | wdata[7:0];
                gpio_reg_clr:  shadow_leds = shadow_leds & ~wdata[7:0];
                default:       shadow_leds = shadow_leds;
            endcase
        end
    endfunction

    function automatic void record_read(input logic [addr_w-1:0] addr,
                                        input logic [data_w-1:0] got, input string name);
        addr_q.push_back(addr);
        cyc_q.push_back(cyc);
        got_q.push_back(got);
        exp_q.push_back(ref_read(addr, cyc));   // cyc still holds the ready cycle here
        name_q.push_back(name);
        issued++;
    endfunction

    function automatic logic [addr_w-1:0] ram_addr(input int word);
        return {region_ram, ram_idx_w'(word), 2'b00};
    endfunction

    function automatic logic [addr_w-1:0] mmio_addr(input logic [15:0] region,
                                                    input logic [1:0] idx);
        return {region, 12'h000, idx, 2'b00};
    endfunction

    task automatic check_leds();
        assert (leds == shadow_leds) else begin
            $display("MISMATCH leds: got 0x%02h, expected 0x%02h", leds, shadow_leds);
            stop_on_failure();
        end
    endtask

    // ======================================================================
    // each master holds its request until its own ready
    // ======================================================================
    task automatic data_access(input logic [addr_w-1:0] addr, input logic wr,
                               input logic [mask_w-1:0] mask, input logic [data_w-1:0] wdata);
        @(negedge pll_clk);
        data_req = '{addr: addr, read: ~wr, write: wr, wmask: mask, wdata: wdata};
        do begin
            @(posedge pll_clk);
        end while (!data_rsp.ready);
        if (wr) begin
            model_write(addr, mask, wdata);
        end else begin
            record_read(addr, data_rsp.rdata, "data_rsp.rdata");
        end
        @(negedge pll_clk);
        data_req = '0;
        check_leds();
    endtask

    task automatic instr_read(input logic [addr_w-1:0] addr);
        @(negedge pll_clk);
        instr_req = '{addr: addr, read: 1'b1};
        do begin
            @(posedge pll_clk);
        end while (!instr_rsp.ready);
        record_read(addr, instr_rsp.rdata, "instr_rsp.rdata");
        @(negedge pll_clk);
        instr_req = '0;
    endtask

    always @(negedge pll_clk) begin : compare_reads
        logic [addr_w-1:0] addr;
        logic [63:0]       cycle;
        logic [data_w-1:0] got;
        logic [data_w-1:0] exp;
        string             name;
        while (got_q.size() != 0) begin
            addr  = addr_q.pop_front();
            cycle = cyc_q.pop_front();
            got   = got_q.pop_front();
            exp   = exp_q.pop_front();
            name  = name_q.pop_front();
            assert (got == exp) else begin
                $display("MISMATCH %s: got 0x%08h, expected 0x%08h at address 0x%08h in cycle %0d",
                         name, got, exp, addr, cycle);
                stop_on_failure();
            end
            checked++;
        end
    end

    // a ready must only reach the master that is asking
    always @(posedge pll_clk) begin
        assert (!instr_rsp.ready || instr_req.read) else begin
            $display("instr_rsp.ready pulsed while the instruction master was idle");
            stop_on_failure();
        end
        assert (!data_rsp.ready || data_req.read || data_req.write) else begin
            $display("data_rsp.ready pulsed while the data master was idle");
            stop_on_failure();
        end
    end

    initial begin : watchdog
        repeat (n_ops * 8 + 200) @(posedge pll_clk);
        $display("watchdog expired, the run did not end within %0d cycles", n_ops * 8 + 200);
        stop_on_failure();
    end

    initial begin : stimulus
        instr_req = '0;
        data_req  = '0;
        void'($urandom(seed));
        wait (arst_n === 1'b1);
        @(negedge pll_clk);
        assert (instr_rsp.ready == 1'b0 && data_rsp.ready == 1'b0) else begin
            $display("MISMATCH instr_rsp.ready/data_rsp.ready: got 0x%0h/0x%0h, expected 0x0/0x0",
                     instr_rsp.ready, data_rsp.ready);
            stop_on_failure();
        end
        check_leds();
        data_access(ram_addr(0), 1'b0, '0, '0);     // nothing written yet

        // ==================================================================
        // RAM, then GPIO, timer and unmapped space
        // ==================================================================
        data_access(ram_addr(ram_words - 1), 1'b1, 4'b1001, 32'hcafe_0123);
        data_access(ram_addr(ram_words - 1), 1'b0, '0, '0);
        for (int i = 0; i < n_ram; i++) begin
            data_access(ram_addr($urandom_range(0, 63)), 1'b1,
                        mask_w'($urandom_range(1, 15)), $urandom());
        end
        for (int i = 0; i < n_ram; i++) begin
            data_access(ram_addr($urandom_range(0, 63)), 1'b0, '0, '0);
        end
        for (int i = 0; i < n_gpio; i++) begin
            data_access(mmio_addr(region_gpio, 2'(i % 3)), 1'b1,
                        mask_w'($urandom_range(0, 15)), $urandom());
            data_access(mmio_addr(region_gpio, 2'($urandom_range(0, 2))), 1'b0, '0, '0);
        end
        data_access(mmio_addr(region_gpio, gpio_reg_data), 1'b1, 4'b1110, 32'h0000_00ff);
        data_access(mmio_addr(region_gpio, gpio_reg_set), 1'b0, '0, '0);
        data_access(mmio_addr(region_timer, timer_reg_lo), 1'b1, 4'hf, 32'h0);
        for (int i = 0; i < n_timer; i++) begin
            data_access(mmio_addr(region_timer, 2'(i % 2)), 1'b0, '0, '0);
        end
        foreach (odd_addr[i]) begin
            data_access(odd_addr[i], 1'b1, 4'hf, $urandom());
        end
        foreach (odd_addr[i]) begin
            data_access(odd_addr[i], 1'b0, '0, '0);
        end
        data_access(mmio_addr(region_gpio, gpio_reg_data), 1'b0, '0, '0);

        // both masters fight for the RAM
        fork
            for (int i = 0; i < n_contend; i++) begin
                repeat ($urandom_range(0, 2)) @(negedge pll_clk);
                instr_read(ram_addr($urandom_range(0, 63)));
            end
            for (int j = 0; j < n_contend; j++) begin
                repeat ($urandom_range(0, 2)) @(negedge pll_clk);
                data_access(ram_addr($urandom_range(0, 63)), 1'b0, '0, '0);
            end
        join

        repeat (2) @(negedge pll_clk);
        if (checked == issued) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("only %0d of %0d reads reached the compare process", checked, issued);
            stop_on_failure();
        end
    end

endmodule

`default_nettype wire

/* soc.f */
rtl/soc_bus_pkg.sv
rtl/soc_map_pkg.sv
rtl/bus_arbiter.sv
rtl/addr_decoder.sv
rtl/bus_ram.sv
rtl/gpio_leds.sv
rtl/cycle_timer.sv
rtl/response_mux.sv
rtl/soc_top.sv
dv/tb_clock.sv
dv/soc_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module soc_tb -f soc.f \
    --Mdir obj_dir -o soc_sim

# the log decides the verdict, so a fatal exit must not stop the script here
./obj_dir/soc_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^Result: PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
